// File: msg_bank.f
msg_bank_cfg_pkg.sv
msg_bank_types_pkg.sv
free_slot_alloc.sv
id_list_ctrl.sv
message_store.sv
release_arbiter.sv
msg_bank_top.sv
tb_msg_bank.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the fail line
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_msg_bank -f msg_bank.f \
  -o sim_msg_bank > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_msg_bank > sim.log 2>&1 || { cat sim.log; echo "Simulator error"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: tb_msg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msg_bank;

  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 10;
  // Rough cycle budget per test, stimulus plus fill and drain
  localparam int TestCycles = 8 + 40 + 100 + 30 + 30 + 60;
  localparam int WatchdogTime = (2 * (ResetCycles + TestCycles) + 100) * ClkPeriod;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic [msg_bank_cfg_pkg::IdWidth-1:0]   resv_id_i;
  logic                                   resv_ready_i;
  logic                                   resv_valid_o;
  msg_bank_types_pkg::resv_rsp_t          resv_rsp_o;
  logic                                   in_valid_i;
  msg_bank_types_pkg::msg_t               in_msg_i;
  logic                                   in_ready_o;
  logic [msg_bank_cfg_pkg::NumIds-1:0]    release_en_i;
  logic                                   out_ready_i;
  logic                                   out_valid_o;
  msg_bank_types_pkg::msg_t               out_msg_o;

  // Reference model, ring buffers of reserved slots and accepted messages per id
  logic [msg_bank_cfg_pkg::Capacity-1:0]  occ;
  logic [msg_bank_cfg_pkg::AddrWidth-1:0] resv_slot [msg_bank_cfg_pkg::NumIds][16];
  logic [4:0]                             resv_rd [msg_bank_cfg_pkg::NumIds];
  logic [4:0]                             resv_wr [msg_bank_cfg_pkg::NumIds];
  msg_bank_types_pkg::msg_t               pend_msg [msg_bank_cfg_pkg::NumIds][16];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0] pend_slot [msg_bank_cfg_pkg::NumIds][16];
  logic [4:0]                             pend_rd [msg_bank_cfg_pkg::NumIds];
  logic [4:0]                             pend_wr [msg_bank_cfg_pkg::NumIds];
  logic                                   exp_out_valid;
  msg_bank_types_pkg::msg_t               exp_out_msg;
  logic [msg_bank_cfg_pkg::NumIds-1:0]    ever_en;
  logic                                   exp_resv_valid;
  logic [msg_bank_cfg_pkg::AddrWidth-1:0] exp_resv_addr;
  logic                                   exp_in_ready;
  int                                     err_cnt;
  int                                     test_cnt;

  msg_bank_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [msg_bank_cfg_pkg::AddrWidth-1:0] first_free(
    input logic [msg_bank_cfg_pkg::Capacity-1:0] map
  );
    for (int i = 0; i < msg_bank_cfg_pkg::Capacity; i++) begin
      if (map[i] == 1'b0) return i[msg_bank_cfg_pkg::AddrWidth-1:0];
    end
    return '0;
  endfunction

  // Lowest id in the mask that still has unfilled reservations, or -1
  function automatic int next_unfilled(input logic [msg_bank_cfg_pkg::NumIds-1:0] mask);
    for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
      if (mask[i] && resv_wr[i] != resv_rd[i]) return i;
    end
    return -1;
  endfunction

  function automatic logic has_pending(input logic [msg_bank_cfg_pkg::NumIds-1:0] mask);
    for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
      if (mask[i] && pend_wr[i] != pend_rd[i]) return 1'b1;
    end
    return 1'b0;
  endfunction

  always_comb begin
    exp_resv_valid = !(&occ);
    exp_resv_addr  = first_free(occ);
    exp_in_ready   = resv_wr[in_msg_i.id] != resv_rd[in_msg_i.id];
  end

  // Decisions use the state before the edge, then pop, intake and reservation apply
  always @(posedge clk_i or negedge rst_ni) begin : model_update
    logic                                   do_resv;
    logic                                   do_in;
    logic                                   do_pop;
    logic [msg_bank_cfg_pkg::AddrWidth-1:0] new_addr;
    logic [msg_bank_cfg_pkg::AddrWidth-1:0] slot;
    logic [msg_bank_cfg_pkg::IdWidth-1:0]   pick;
    logic [msg_bank_cfg_pkg::IdWidth-1:0]   id;
    if (!rst_ni) begin
      occ           = '0;
      exp_out_valid = 1'b0;
      exp_out_msg   = '0;
      ever_en       = '0;
      for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
        resv_rd[i] = '0;
        resv_wr[i] = '0;
        pend_rd[i] = '0;
        pend_wr[i] = '0;
      end
    end else begin
      do_resv  = exp_resv_valid && resv_ready_i;
      new_addr = exp_resv_addr;
      do_in    = in_valid_i && exp_in_ready;
      do_pop   = 1'b0;
      pick     = '0;
      for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
        if (!do_pop && release_en_i[i] && pend_wr[i] != pend_rd[i]) begin
          do_pop = 1'b1;
          pick   = i[msg_bank_cfg_pkg::IdWidth-1:0];
        end
      end
      if (exp_out_valid && !out_ready_i) do_pop = 1'b0;
      ever_en = ever_en | release_en_i;
      if (do_pop) begin
        exp_out_msg   = pend_msg[pick][pend_rd[pick][3:0]];
        occ[pend_slot[pick][pend_rd[pick][3:0]]] = 1'b0;
        pend_rd[pick] = pend_rd[pick] + 5'd1;
        exp_out_valid = 1'b1;
      end else if (out_ready_i) begin
        exp_out_valid = 1'b0;
      end
      if (do_in) begin
        id          = in_msg_i.id;
        slot        = resv_slot[id][resv_rd[id][3:0]];
        resv_rd[id] = resv_rd[id] + 5'd1;
        pend_msg[id][pend_wr[id][3:0]]  = in_msg_i;
        pend_slot[id][pend_wr[id][3:0]] = slot;
        pend_wr[id] = pend_wr[id] + 5'd1;
      end
      if (do_resv) begin
        occ[new_addr] = 1'b1;
        resv_slot[resv_id_i][resv_wr[resv_id_i][3:0]] = new_addr;
        resv_wr[resv_id_i] = resv_wr[resv_id_i] + 5'd1;
      end
    end
  end

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
    $display("FAILED %s: expected %h, actual %h", name, expv, actv);
    err_cnt++;
  endtask

  task automatic report_text(input string what);
    $display("Check failed, %s", what);
    err_cnt++;
  endtask

  a_resv_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resv_valid_o == exp_resv_valid)
    else report_value("resv_valid_o", 32'($sampled(exp_resv_valid)), 32'($sampled(resv_valid_o)));
  a_resv_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_resv_valid |-> resv_rsp_o.addr == exp_resv_addr)
    else report_value("resv_rsp_o", 32'($sampled(exp_resv_addr)), 32'($sampled(resv_rsp_o)));
  a_in_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o == exp_in_ready)
    else report_value("in_ready_o", 32'($sampled(exp_in_ready)), 32'($sampled(in_ready_o)));
  a_out_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o == exp_out_valid)
    else report_value("out_valid_o", 32'($sampled(exp_out_valid)), 32'($sampled(out_valid_o)));
  a_out_msg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_out_valid |-> out_msg_o == exp_out_msg)
    else report_value("out_msg_o", $sampled(exp_out_msg), $sampled(out_msg_o));
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> ($stable(out_valid_o) && $stable(out_msg_o)))
    else report_text("output changed while the receiver held it back");
  a_never_enabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> ever_en[out_msg_o.id])
    else report_text("a message of an id that was never enabled came out");

  task automatic reserve(input logic [msg_bank_cfg_pkg::IdWidth-1:0] id);
    resv_id_i    = id;
    resv_ready_i = 1'b1;
    @(negedge clk_i);
    resv_ready_i = 1'b0;
  endtask

  // Send one message for every open reservation of the ids in the mask
  task automatic fill_open(input logic [msg_bank_cfg_pkg::NumIds-1:0] mask);
    logic [31:0] r;
    int          id;
    id = next_unfilled(mask);
    while (id >= 0) begin
      r                = $urandom;
      in_valid_i       = 1'b1;
      in_msg_i.id      = id[msg_bank_cfg_pkg::IdWidth-1:0];
      in_msg_i.payload = r[msg_bank_cfg_pkg::PayloadWidth-1:0];
      @(negedge clk_i);
      id = next_unfilled(mask);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic drain(input logic [msg_bank_cfg_pkg::NumIds-1:0] en);
    release_en_i = en;
    out_ready_i  = 1'b1;
    while (has_pending(en) || out_valid_o) @(negedge clk_i);
    release_en_i = '0;
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_cnt++;
    $display("test %0d %s: %0d failed checks", test_cnt, name, err_cnt - err_start);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    int          err_start;
    int          n;
    void'($urandom(79079));
    err_cnt      = 0;
    test_cnt     = 0;
    rst_ni       = 1'b0;
    resv_id_i    = '0;
    resv_ready_i = 1'b0;
    in_valid_i   = 1'b0;
    in_msg_i     = '0;
    release_en_i = '0;
    out_ready_i  = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    err_start = err_cnt;
    @(negedge clk_i);
    for (int k = 0; k < 8; k++) reserve(k[1:0]);
    finish_test("reset_and_alloc_order", err_start);

    // Id 2 is never enabled, so its messages stay in the bank
    err_start = err_cnt;
    for (int k = 0; k < 24; k++) begin
      r          = $urandom;
      r2         = $urandom;
      in_valid_i = 1'b1;
      in_msg_i.id      = r[1:0];
      in_msg_i.payload = r2[msg_bank_cfg_pkg::PayloadWidth-1:0];
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
    fill_open(4'b1111);
    finish_test("intake_gating", err_start);

    err_start    = err_cnt;
    release_en_i = 4'b1011;
    for (int k = 0; k < 60; k++) begin
      r                = $urandom;
      r2               = $urandom;
      resv_ready_i     = r[0];
      resv_id_i        = (r[2:1] == 2'd2) ? 2'd3 : r[2:1];
      in_valid_i       = r[3];
      in_msg_i.id      = (r[5:4] == 2'd2) ? 2'd3 : r[5:4];
      in_msg_i.payload = r2[msg_bank_cfg_pkg::PayloadWidth-1:0];
      out_ready_i      = r[6] | r[7];
      @(negedge clk_i);
    end
    resv_ready_i = 1'b0;
    in_valid_i   = 1'b0;
    fill_open(4'b1011);
    drain(4'b1011);
    finish_test("order_and_data", err_start);

    err_start = err_cnt;
    for (int k = 0; k < 6; k++) reserve(k[0] ? 2'd3 : 2'd1);
    fill_open(4'b1010);
    repeat (4) @(negedge clk_i);
    drain(4'b1010);
    finish_test("enable_and_priority", err_start);

    err_start = err_cnt;
    for (int k = 0; k < 4; k++) reserve(2'd0);
    fill_open(4'b0001);
    release_en_i = 4'b0001;
    n = 0;
    while (has_pending(4'b0001) || out_valid_o) begin
      out_ready_i = (n % 4) == 3;
      n++;
      @(negedge clk_i);
    end
    release_en_i = '0;
    out_ready_i  = 1'b1;
    finish_test("back_pressure", err_start);

    err_start    = err_cnt;
    resv_id_i    = 2'd0;
    resv_ready_i = 1'b1;
    n = 0;
    while (resv_valid_o && n <= msg_bank_cfg_pkg::Capacity) begin
      @(negedge clk_i);
      n++;
    end
    resv_ready_i = 1'b0;
    if (resv_valid_o) report_text("the bank never reported itself full");
    fill_open(4'b0001);
    release_en_i = 4'b0001;
    @(negedge clk_i);
    release_en_i = '0;
    n = 0;
    while (!resv_valid_o && n < 4) begin
      @(negedge clk_i);
      n++;
    end
    if (!resv_valid_o) report_text("no slot came free after a release");
    drain(4'b0001);
    finish_test("full_and_recovery", err_start);

    repeat (2) @(negedge clk_i);
    $display("tests run %0d, failed checks %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WatchdogTime);
    $display("Timeout, the tests did not finish in the expected time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: msg_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module msg_bank_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Reservation
  input  logic [msg_bank_cfg_pkg::IdWidth-1:0] resv_id_i,
  input  logic                                 resv_ready_i,
  output logic                                 resv_valid_o,
  output msg_bank_types_pkg::resv_rsp_t        resv_rsp_o,
  // Intake
  input  logic                                 in_valid_i,
  input  msg_bank_types_pkg::msg_t             in_msg_i,
  output logic                                 in_ready_o,
  // Release
  input  logic [msg_bank_cfg_pkg::NumIds-1:0]  release_en_i,
  input  logic                                 out_ready_i,
  output logic                                 out_valid_o,
  output msg_bank_types_pkg::msg_t             out_msg_o
);

  logic                                    alloc;
  logic                                    wr_en;
  msg_bank_types_pkg::store_wr_t           wr;
  logic [msg_bank_cfg_pkg::NumIds-1:0]     filled;
  logic                                    pop;
  logic [msg_bank_cfg_pkg::IdWidth-1:0]    pop_id;
  msg_bank_types_pkg::release_sel_t        release_sel;

  free_slot_alloc u_free_slot_alloc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .resv_ready_i (resv_ready_i),
    .free_en_i    (pop),
    .free_addr_i  (release_sel.addr),
    .resv_valid_o (resv_valid_o),
    .resv_rsp_o   (resv_rsp_o),
    .alloc_o      (alloc)
  );

  id_list_ctrl u_id_list_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alloc_i       (alloc),
    .alloc_addr_i  (resv_rsp_o),
    .resv_id_i     (resv_id_i),
    .in_valid_i    (in_valid_i),
    .in_msg_i      (in_msg_i),
    .pop_i         (pop),
    .pop_id_i      (pop_id),
    .in_ready_o    (in_ready_o),
    .wr_en_o       (wr_en),
    .wr_o          (wr),
    .filled_o      (filled),
    .release_sel_o (release_sel)
  );

  message_store u_message_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (wr_en),
    .wr_i      (wr),
    .rd_en_i   (pop),
    .rd_addr_i (release_sel.addr),
    .rd_msg_o  (out_msg_o)
  );

  release_arbiter u_release_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .filled_i     (filled),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .pop_o        (pop),
    .pop_id_o     (pop_id),
    .out_valid_o  (out_valid_o)
  );

endmodule

`default_nettype wire

// File: release_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module release_arbiter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [msg_bank_cfg_pkg::NumIds-1:0]  filled_i,
  input  logic [msg_bank_cfg_pkg::NumIds-1:0]  release_en_i,
  input  logic                                 out_ready_i,
  output logic                                 pop_o,
  output logic [msg_bank_cfg_pkg::IdWidth-1:0] pop_id_o,
  output logic                                 out_valid_o
);

  logic [msg_bank_cfg_pkg::NumIds-1:0]  cand;
  logic [msg_bank_cfg_pkg::IdWidth-1:0] pick;
  logic                                 out_free;
  logic                                 out_valid_q;
  logic                                 out_valid_d;

  // Only ids that hold a message and are let through compete
  assign cand = filled_i & release_en_i;

  // Lowest enabled id has priority
  always_comb begin
    pick = '0;
    for (int i = msg_bank_cfg_pkg::NumIds - 1; i >= 0; i--) begin
      if (cand[i]) begin
        pick = i[msg_bank_cfg_pkg::IdWidth-1:0];
      end
    end
  end

  // Output register is free when empty or being taken this cycle
  assign out_free = !out_valid_q || out_ready_i;
  assign pop_o    = |cand && out_free;
  assign pop_id_o = pick;

  always_comb begin
    out_valid_d = out_valid_q;
    if (pop_o) begin
      out_valid_d = 1'b1;
    end else if (out_ready_i) begin
      out_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= out_valid_d;
    end
  end

  assign out_valid_o = out_valid_q;

  // A presented message stays until the receiver takes it
  a_valid_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> out_valid_o
  );

endmodule

`default_nettype wire

// File: message_store.sv
`timescale 1ns/1ps
`default_nettype none

module message_store (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   wr_en_i,
  input  msg_bank_types_pkg::store_wr_t          wr_i,
  input  logic                                   rd_en_i,
  input  logic [msg_bank_cfg_pkg::AddrWidth-1:0] rd_addr_i,
  output msg_bank_types_pkg::msg_t               rd_msg_o
);

  msg_bank_types_pkg::msg_t mem_q [msg_bank_cfg_pkg::Capacity];
  msg_bank_types_pkg::msg_t rd_q;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_i.addr] <= wr_i.msg;
    end
  end

  // Read data only moves on a pop and holds under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= '0;
    end else if (rd_en_i) begin
      rd_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_msg_o = rd_q;

endmodule

`default_nettype wire

// File: id_list_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module id_list_ctrl (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      alloc_i,
  input  msg_bank_types_pkg::resv_rsp_t             alloc_addr_i,
  input  logic [msg_bank_cfg_pkg::IdWidth-1:0]      resv_id_i,
  input  logic                                      in_valid_i,
  input  msg_bank_types_pkg::msg_t                  in_msg_i,
  input  logic                                      pop_i,
  input  logic [msg_bank_cfg_pkg::IdWidth-1:0]      pop_id_i,
  output logic                                      in_ready_o,
  output logic                                      wr_en_o,
  output msg_bank_types_pkg::store_wr_t             wr_o,
  output logic [msg_bank_cfg_pkg::NumIds-1:0]       filled_o,
  output msg_bank_types_pkg::release_sel_t          release_sel_o
);

  // Chain order per id is head .. filled .. fill .. unfilled .. tail
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  head_q [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  head_d [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  fill_q [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  fill_d [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  tail_q [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  tail_d [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] filled_cnt_q [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] filled_cnt_d [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] unfilled_cnt_q [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] unfilled_cnt_d [msg_bank_cfg_pkg::NumIds];

  // Next-slot link for every slot of the store
  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  next_q [msg_bank_cfg_pkg::Capacity];

  // Per-id increments, at most one bit set in each array
  logic [msg_bank_cfg_pkg::CountWidth-1:0] resv_inc [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] in_inc [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] pop_dec [msg_bank_cfg_pkg::NumIds];

  // Counts after this cycle's intake and pop, before the reservation
  logic [msg_bank_cfg_pkg::CountWidth-1:0] unfilled_eff [msg_bank_cfg_pkg::NumIds];
  logic [msg_bank_cfg_pkg::CountWidth-1:0] total_eff [msg_bank_cfg_pkg::NumIds];

  logic [msg_bank_cfg_pkg::AddrWidth-1:0]  new_addr;
  logic [msg_bank_cfg_pkg::IdWidth-1:0]    in_id;
  logic                                    in_fire;
  logic                                    link_en;

  assign new_addr   = alloc_addr_i.addr;
  assign in_id      = in_msg_i.id;
  assign in_ready_o = unfilled_cnt_q[in_id] != '0;
  assign in_fire    = in_valid_i && in_ready_o;

  // Intake lands in the oldest unfilled slot of its id
  assign wr_en_o  = in_fire;
  assign wr_o.addr = fill_q[in_id];
  assign wr_o.msg  = in_msg_i;

  assign release_sel_o.id   = pop_id_i;
  assign release_sel_o.addr = head_q[pop_id_i];

  always_comb begin
    for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
      resv_inc[i] = '0;
      in_inc[i]   = '0;
      pop_dec[i]  = '0;
    end
    resv_inc[resv_id_i] = {{(msg_bank_cfg_pkg::CountWidth-1){1'b0}}, alloc_i};
    in_inc[in_id]       = {{(msg_bank_cfg_pkg::CountWidth-1){1'b0}}, in_fire};
    pop_dec[pop_id_i]   = {{(msg_bank_cfg_pkg::CountWidth-1){1'b0}}, pop_i};
  end

  always_comb begin
    for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
      unfilled_eff[i]   = unfilled_cnt_q[i] - in_inc[i];
      total_eff[i]      = filled_cnt_q[i] + unfilled_cnt_q[i] - pop_dec[i];
      filled_cnt_d[i]   = filled_cnt_q[i] + in_inc[i] - pop_dec[i];
      unfilled_cnt_d[i] = unfilled_eff[i] + resv_inc[i];
      filled_o[i]       = filled_cnt_q[i] != '0;

      head_d[i] = head_q[i];
      fill_d[i] = fill_q[i];
      tail_d[i] = tail_q[i];
      if (in_inc[i][0]) begin
        fill_d[i] = next_q[fill_q[i]];
      end
      if (pop_dec[i][0]) begin
        head_d[i] = next_q[head_q[i]];
      end
      // A new slot seeds any pointer whose link would still be unwritten
      if (resv_inc[i][0]) begin
        tail_d[i] = new_addr;
        if (unfilled_eff[i] == '0) begin
          fill_d[i] = new_addr;
        end
        if (total_eff[i] == '0) begin
          head_d[i] = new_addr;
        end
      end
    end
  end

  // Link only behind a live tail, a stale tail may now sit in another chain
  assign link_en = alloc_i && (total_eff[resv_id_i] != '0);

  always_ff @(posedge clk_i) begin
    if (link_en) begin
      next_q[tail_q[resv_id_i]] <= new_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
        head_q[i]         <= '0;
        fill_q[i]         <= '0;
        tail_q[i]         <= '0;
        filled_cnt_q[i]   <= '0;
        unfilled_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < msg_bank_cfg_pkg::NumIds; i++) begin
        head_q[i]         <= head_d[i];
        fill_q[i]         <= fill_d[i];
        tail_q[i]         <= tail_d[i];
        filled_cnt_q[i]   <= filled_cnt_d[i];
        unfilled_cnt_q[i] <= unfilled_cnt_d[i];
      end
    end
  end

  // The arbiter only pops ids that hold a filled message
  a_pop_has_msg: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (filled_cnt_q[pop_id_i] != '0)
  );

  for (genvar g = 0; g < msg_bank_cfg_pkg::NumIds; g++) begin : gen_bound_chk
    a_count_bound: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ({1'b0, filled_cnt_q[g]} + {1'b0, unfilled_cnt_q[g]}) <= msg_bank_cfg_pkg::Capacity
    );
  end

endmodule

`default_nettype wire

// File: free_slot_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module free_slot_alloc (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   resv_ready_i,
  input  logic                                   free_en_i,
  input  logic [msg_bank_cfg_pkg::AddrWidth-1:0] free_addr_i,
  output logic                                   resv_valid_o,
  output msg_bank_types_pkg::resv_rsp_t          resv_rsp_o,
  output logic                                   alloc_o
);

  // One bit per slot, set while the slot belongs to some chain
  logic [msg_bank_cfg_pkg::Capacity-1:0] occ_q;
  logic [msg_bank_cfg_pkg::Capacity-1:0] occ_d;
  logic [msg_bank_cfg_pkg::AddrWidth-1:0] lowest_free;

  // Priority encoder, scanning down so the lowest zero bit wins
  always_comb begin
    lowest_free = '0;
    for (int i = msg_bank_cfg_pkg::Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        lowest_free = i[msg_bank_cfg_pkg::AddrWidth-1:0];
      end
    end
  end

  assign resv_valid_o    = ~&occ_q;
  assign resv_rsp_o.addr = lowest_free;
  assign alloc_o         = resv_valid_o && resv_ready_i;

  // The freed slot is occupied this cycle, so it never collides with the grant
  always_comb begin
    occ_d = occ_q;
    if (free_en_i) begin
      occ_d[free_addr_i] = 1'b0;
    end
    if (alloc_o) begin
      occ_d[lowest_free] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // A pop frees a slot that the chains still held
  a_free_was_occupied: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    free_en_i |-> occ_q[free_addr_i]
  );

endmodule

`default_nettype wire

// File: msg_bank_types_pkg.sv
`default_nettype none

package msg_bank_types_pkg;

  // Identifier sits in the low bits of the message word
  typedef struct packed {
    logic [msg_bank_cfg_pkg::PayloadWidth-1:0] payload;
    logic [msg_bank_cfg_pkg::IdWidth-1:0]      id;
  } msg_t;

  // Slot granted to a reservation
  typedef struct packed {
    logic [msg_bank_cfg_pkg::AddrWidth-1:0] addr;
  } resv_rsp_t;

  // One write into the message store
  typedef struct packed {
    logic [msg_bank_cfg_pkg::AddrWidth-1:0] addr;
    msg_t                                   msg;
  } store_wr_t;

  // Identifier being released and the slot at the head of its chain
  typedef struct packed {
    logic [msg_bank_cfg_pkg::IdWidth-1:0]   id;
    logic [msg_bank_cfg_pkg::AddrWidth-1:0] addr;
  } release_sel_t;

endpackage

`default_nettype wire

// File: msg_bank_cfg_pkg.sv
`default_nettype none

package msg_bank_cfg_pkg;

  // Identifier space
  localparam int NumIds = 4;
  localparam int IdWidth = 2;

  // Shared message store
  localparam int Capacity = 16;
  localparam int AddrWidth = 4;

  // Per-identifier counters must reach Capacity itself
  localparam int CountWidth = 5;

  // A message is the payload plus its identifier, 32 bits in all
  localparam int PayloadWidth = 30;

endpackage

`default_nettype wire
